// File: design/drac_pkg.sv
/*
 * Datapath types shared by the narrowing clip unit:
 * operand word, opcode and element width enums, controller states
 */

package drac_pkg;

    typedef logic [63:0] bus64_t;  // operand or result word

    typedef enum logic [0:0] {
        VNCLIP  = 1'b0,            // signed clip
        VNCLIPU = 1'b1             // unsigned clip
    } instr_type_t;

    // destination element width, source lanes are twice as wide
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        FLUSH = 2'd2               // last packed word leaving
    } ctrl_state_t;

endpackage

// File: design/riscv_pkg.sv
/*
 * ISA encodings used by the vector fixed-point path
 */

package riscv_pkg;

    // vxrm field, same order as the CSR encoding
    typedef enum logic [1:0] {
        RNU_V = 2'd0,  // round to nearest up
        RNE_V = 2'd1,  // round to nearest even
        RDN_V = 2'd2,  // round down (truncate)
        ROD_V = 2'd3   // round to odd
    } vxrm_t;

endpackage

// File: design/beat_counter.sv
/*
 * Down-counter of remaining source words with last-word flag
 */

`timescale 1ns/1ps

module beat_counter #(
    parameter int CNT_W = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             load_i,
    input  logic [CNT_W-1:0] init_i,
    input  logic             dec_i,
    output logic             last_o
);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= init_i;
        end else if (dec_i && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign last_o = (count_q == CNT_W'(1));

endmodule

// File: design/narrow_packer.sv
/*
 * Joins two narrowed halves into one destination word,
 * zero pads a lone half on flush
 */

`timescale 1ns/1ps

module narrow_packer
    import drac_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   beat_i,
    input  logic   flush_i,    // last beat of the operation
    input  bus64_t half_i,     // narrowed half in [31:0]
    output bus64_t data_vd_o,
    output logic   valid_o
);

    logic        phase_q;     // low half held
    logic [31:0] low_q;
    bus64_t      data_q;
    logic        valid_q;
    logic        emit;

    assign emit = beat_i && (phase_q || flush_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            phase_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= emit;
            if (beat_i) begin
                phase_q <= flush_i ? 1'b0 : ~phase_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_i && !phase_q) begin
            low_q <= half_i[31:0];
        end
        if (emit) begin
            data_q <= phase_q ? {half_i[31:0], low_q} : {32'h0, half_i[31:0]};
        end
    end

    assign data_vd_o = data_q;
    assign valid_o   = valid_q;

endmodule

// File: design/vnclip.sv
/*
 * Narrowing shift, round and saturate of one 64-bit source word.
 * Handles vnclip and vnclipu for SEW 8, 16 and 32.
 */

`timescale 1ns/1ps

module vnclip
    import drac_pkg::*;
    import riscv_pkg::*;
(
    input  instr_type_t instr_type_i,  // signed or unsigned clip
    input  sew_t        sew_i,         // destination element width
    input  vxrm_t       vxrm_i,        // rounding mode
    input  bus64_t      data_vs1_i,    // shift amounts
    input  bus64_t      data_vs2_i,    // wide source lanes
    output bus64_t      data_vd_o,     // narrowed half in [31:0]
    output logic        sat_ovf_o      // any lane clamped
);

    // sign or zero extend the low sw bits of raw to 65 bits
    function automatic logic [64:0] ext_lane(
        input bus64_t      raw,
        input int unsigned sw,
        input logic        sgn
    );
        logic [64:0] upper;
        logic [64:0] v;
        upper = {65{1'b1}} << sw;
        v     = {1'b0, raw} & ~upper;
        if (sgn && raw[sw-1]) begin
            v = v | upper;
        end
        return v;
    endfunction

    // shift, round and clamp one extended lane to w bits
    function automatic logic [31:0] clip_lane(
        input  logic [64:0] v,
        input  logic [5:0]  d,
        input  vxrm_t       rm,
        input  logic        sgn,
        input  int unsigned w,
        output logic        sat
    );
        logic signed [64:0] shifted;
        logic signed [65:0] sum;
        logic signed [65:0] lim_hi;
        logic signed [65:0] lim_lo;
        logic [64:0]        below;
        logic               r;
        logic [31:0]        res;

        shifted = $signed(v) >>> d;
        r       = 1'b0;
        below   = '0;
        if (d != 6'd0) begin
            below = v & ~({65{1'b1}} << (d - 1));  // bits d-2..0
            case (rm)
                RNU_V:   r = v[d-1];
                RNE_V:   r = v[d-1] & ((below != '0) | v[d]);
                RDN_V:   r = 1'b0;
                ROD_V:   r = ~v[d] & (v[d-1] | (below != '0));
                default: r = 1'b0;
            endcase
        end

        // 66 bits so the increment never wraps
        sum = {shifted[64], shifted} + {65'd0, r};

        lim_hi = sgn ? ((66'sd1 <<< (w - 1)) - 66'sd1) : ((66'sd1 <<< w) - 66'sd1);
        lim_lo = sgn ? -(66'sd1 <<< (w - 1)) : 66'sd0;

        sat = 1'b0;
        if (sum > lim_hi) begin
            sat = 1'b1;
            res = lim_hi[31:0];
        end else if (sum < lim_lo) begin
            sat = 1'b1;
            res = lim_lo[31:0];  // low w bits hold the min
        end else begin
            res = sum[31:0];
        end
        return res;
    endfunction

    logic        sgn;
    logic [31:0] narrow;
    logic [31:0] lane_res;
    logic        lane_sat;
    logic        sat_any;

    assign sgn = (instr_type_i == VNCLIP);

    always_comb begin
        narrow   = '0;
        sat_any  = 1'b0;
        lane_res = '0;
        lane_sat = 1'b0;
        case (sew_i)
            SEW_32: begin
                lane_res = clip_lane(ext_lane(data_vs2_i, 64, sgn), data_vs1_i[5:0],
                                     vxrm_i, sgn, 32, lane_sat);
                narrow   = lane_res;
                sat_any  = lane_sat;
            end
            SEW_16: begin
                for (int i = 0; i < 2; i++) begin
                    lane_res = clip_lane(ext_lane(data_vs2_i >> (i * 32), 32, sgn),
                                         {1'b0, data_vs1_i[i*16 +: 5]},
                                         vxrm_i, sgn, 16, lane_sat);
                    narrow[i*16 +: 16] = lane_res[15:0];
                    sat_any = sat_any | lane_sat;
                end
            end
            SEW_8: begin
                for (int i = 0; i < 4; i++) begin
                    lane_res = clip_lane(ext_lane(data_vs2_i >> (i * 16), 16, sgn),
                                         {2'b00, data_vs1_i[i*8 +: 4]},
                                         vxrm_i, sgn, 8, lane_sat);
                    narrow[i*8 +: 8] = lane_res[7:0];
                    sat_any = sat_any | lane_sat;
                end
            end
            default: begin
                narrow  = '0;
                sat_any = 1'b0;
            end
        endcase
    end

    assign data_vd_o = {32'h0, narrow};
    assign sat_ovf_o = sat_any;

endmodule

// File: design/vnclip_ctrl.sv
/*
 * Operation FSM of the clip unit: latches the configuration,
 * gates source beats and keeps the sticky vxsat flag
 */

`timescale 1ns/1ps

module vnclip_ctrl
    import drac_pkg::*;
    import riscv_pkg::*;
#(
    parameter int CNT_W = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  instr_type_t      instr_type_i,
    input  sew_t             sew_i,
    input  vxrm_t            vxrm_i,
    input  logic [CNT_W-1:0] n_words_i,
    input  logic             in_valid_i,
    input  logic             last_i,       // one word left
    input  logic             sat_ovf_i,
    output logic             load_o,
    output logic [CNT_W-1:0] cnt_init_o,
    output logic             beat_o,       // accepted source word
    output logic             flush_o,
    output instr_type_t      instr_type_o,
    output sew_t             sew_o,
    output vxrm_t            vxrm_o,
    output logic             busy_o,
    output logic             done_o,
    output logic             vxsat_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    instr_type_t instr_type_q;
    sew_t        sew_q;
    vxrm_t       vxrm_q;
    logic        vxsat_q;
    logic        start_ok;

    assign start_ok   = start_i && (state_q == IDLE);  // busy starts dropped
    assign load_o     = start_ok;
    assign cnt_init_o = n_words_i;
    assign beat_o     = in_valid_i && (state_q == RUN);
    assign flush_o    = beat_o && last_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_ok) state_d = RUN;
            RUN:     if (flush_o) state_d = FLUSH;
            FLUSH:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            vxsat_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_ok) begin
                vxsat_q <= 1'b0;
            end else if (beat_o && sat_ovf_i) begin
                vxsat_q <= 1'b1;  // sticky until next start
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            instr_type_q <= instr_type_i;
            sew_q        <= sew_i;
            vxrm_q       <= vxrm_i;
        end
    end

    assign instr_type_o = instr_type_q;
    assign sew_o        = sew_q;
    assign vxrm_o       = vxrm_q;
    assign busy_o       = (state_q != IDLE);
    assign done_o       = (state_q == FLUSH);
    assign vxsat_o      = vxsat_q;

endmodule

// File: design/vnclip_unit.sv
/*
 * Top of the narrowing clip unit: controller, beat counter,
 * vnclip datapath and output packer
 */

`timescale 1ns/1ps

module vnclip_unit
    import drac_pkg::*;
    import riscv_pkg::*;
#(
    parameter int CNT_W = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  instr_type_t      instr_type_i,
    input  sew_t             sew_i,
    input  vxrm_t            vxrm_i,
    input  logic [CNT_W-1:0] n_words_i,
    input  logic             in_valid_i,
    input  bus64_t           data_vs1_i,
    input  bus64_t           data_vs2_i,
    output bus64_t           data_vd_o,
    output logic             out_valid_o,
    output logic             busy_o,
    output logic             done_o,
    output logic             vxsat_o
);

    logic             load;
    logic [CNT_W-1:0] cnt_init;
    logic             beat;
    logic             flush;
    logic             last;
    logic             sat_ovf;
    instr_type_t      instr_type;
    sew_t             sew;
    vxrm_t            vxrm;
    bus64_t           half;

    vnclip_ctrl #(
        .CNT_W(CNT_W)
    ) u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .vxrm_i       (vxrm_i),
        .n_words_i    (n_words_i),
        .in_valid_i   (in_valid_i),
        .last_i       (last),
        .sat_ovf_i    (sat_ovf),
        .load_o       (load),
        .cnt_init_o   (cnt_init),
        .beat_o       (beat),
        .flush_o      (flush),
        .instr_type_o (instr_type),
        .sew_o        (sew),
        .vxrm_o       (vxrm),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .vxsat_o      (vxsat_o)
    );

    beat_counter #(
        .CNT_W(CNT_W)
    ) u_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (load),
        .init_i  (cnt_init),
        .dec_i   (beat),
        .last_o  (last)
    );

    vnclip u_clip (
        .instr_type_i (instr_type),
        .sew_i        (sew),
        .vxrm_i       (vxrm),
        .data_vs1_i   (data_vs1_i),
        .data_vs2_i   (data_vs2_i),
        .data_vd_o    (half),
        .sat_ovf_o    (sat_ovf)
    );

    narrow_packer u_pack (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .beat_i    (beat),
        .flush_i   (flush),
        .half_i    (half),
        .data_vd_o (data_vd_o),
        .valid_o   (out_valid_o)
    );

endmodule

// File: tb/vnclip_unit_sva.sv
/*
 * Bound checker on the control outputs of the clip unit
 */

`timescale 1ns/1ps

module vnclip_unit_sva
    import drac_pkg::*;
(
    input logic        clk_i,
    input logic        rst_n_i,
    input ctrl_state_t state_i,
    input logic        out_valid_i,
    input logic        busy_i,
    input logic        done_i
);

    // final word leaves together with done
    a_done_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |-> out_valid_i) else $error("done_o without out_valid_o");

    a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i |-> (state_i != IDLE)) else $error("out_valid_o while the FSM is idle");

    a_done_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> !busy_i) else $error("busy_o still high after done_o");

endmodule

bind vnclip_unit vnclip_unit_sva u_sva (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .state_i     (u_ctrl.state_q),
    .out_valid_i (out_valid_o),
    .busy_i      (busy_o),
    .done_i      (done_o)
);

// File: tb/vnclip_model.svh
/*
 * Reference model of the narrowing clip: one lane, one source word
 * and the packing of two narrowed halves into a destination word
 */

`ifndef VNCLIP_MODEL_SVH
`define VNCLIP_MODEL_SVH

// sw-bit source lane, shift d, clamp to w bits
function automatic logic [31:0] ref_clip_lane(
    input  bus64_t src,
    input  int     sw,
    input  int     d,
    input  logic   sgn,
    input  vxrm_t  rm,
    input  int     w,
    output logic   sat
);
    logic signed [67:0] val;
    logic signed [67:0] q;
    logic signed [67:0] max_v;
    logic signed [67:0] min_v;
    logic               r;
    logic               rest;
    for (int b = 0; b < 68; b++) begin
        if (b < sw) begin
            val[b] = src[b];
        end else begin
            val[b] = sgn & src[sw-1];  // sign or zero fill
        end
    end
    q    = val >>> d;
    r    = 1'b0;
    rest = 1'b0;
    if (d > 0) begin
        for (int b = 0; b < d - 1; b++) begin
            rest = rest | val[b];      // bits below the round bit
        end
        case (rm)
            RNU_V:   r = val[d-1];
            RNE_V:   r = val[d-1] & (rest | val[d]);
            ROD_V:   r = ~val[d] & (val[d-1] | rest);
            default: r = 1'b0;         // truncate
        endcase
    end
    if (r) begin
        q = q + 68'sd1;
    end
    if (sgn) begin
        max_v = (68'sd1 <<< (w - 1)) - 68'sd1;
        min_v = -(68'sd1 <<< (w - 1));
    end else begin
        max_v = (68'sd1 <<< w) - 68'sd1;
        min_v = 68'sd0;
    end
    sat = (q > max_v) || (q < min_v);
    if (q > max_v) begin
        q = max_v;
    end else if (q < min_v) begin
        q = min_v;
    end
    return q[31:0];
endfunction

// all lanes of one source word, lane 0 lowest
function automatic logic [31:0] ref_narrow_word(
    input  instr_type_t it,
    input  sew_t        sew,
    input  vxrm_t       rm,
    input  bus64_t      vs1,
    input  bus64_t      vs2,
    output logic        sat
);
    int          lanes;
    int          w;
    int          d;
    logic        lane_sat;
    logic [31:0] lane;
    logic [31:0] res;
    case (sew)
        SEW_32: begin
            lanes = 1;
            w     = 32;
        end
        SEW_16: begin
            lanes = 2;
            w     = 16;
        end
        default: begin
            lanes = 4;
            w     = 8;
        end
    endcase
    res = '0;
    sat = 1'b0;
    for (int i = 0; i < lanes; i++) begin
        if (sew == SEW_32) begin
            d = int'(vs1[5:0]);
        end else if (sew == SEW_16) begin
            d = int'((vs1 >> (i * 16)) & 64'h1f);
        end else begin
            d = int'((vs1 >> (i * 8)) & 64'hf);
        end
        lane = ref_clip_lane(vs2 >> (i * 2 * w), 2 * w, d, it == VNCLIP, rm, w, lane_sat);
        res  = res | ((lane & ((32'd1 << w) - 32'd1)) << (i * w));
        sat  = sat | lane_sat;
    end
    return res;
endfunction

function automatic bus64_t ref_pack(
    input logic [31:0] lo,
    input logic [31:0] hi,
    input logic        has_hi   // low when a lone half is flushed
);
    return has_hi ? {hi, lo} : {32'h0, lo};
endfunction

`endif

// File: tb/vnclip_unit_tb.sv
/*
 * Testbench of the narrowing clip unit: clock, reset, LFSR stimulus,
 * output monitor, compare tasks, directed tests and timeout
 */

`timescale 1ns/1ps

module vnclip_unit_tb
    import drac_pkg::*;
    import riscv_pkg::*;
();

    `include "vnclip_model.svh"

    localparam int CNT_W          = 8;
    localparam int TOTAL_BEATS    = 70;  // 4 + 8 + 7 + 11 + 40
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 200;

    logic             clk;
    logic             rst_n;
    logic             start;
    instr_type_t      instr_type;
    sew_t             sew;
    vxrm_t            vxrm;
    logic [CNT_W-1:0] n_words;
    logic             in_valid;
    bus64_t           vs1;
    bus64_t           vs2;
    bus64_t           vd;
    logic             out_valid;
    logic             busy;
    logic             done;
    logic             vxsat;

    logic [31:0] lfsr_state = 32'h1f99_1494;
    bus64_t      vs1_q[$];
    bus64_t      vs2_q[$];
    bus64_t      exp_q[$];  // destination words still due
    int          cycles  = 0;

    vnclip_unit #(
        .CNT_W(CNT_W)
    ) u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .instr_type_i (instr_type),
        .sew_i        (sew),
        .vxrm_i       (vxrm),
        .n_words_i    (n_words),
        .in_valid_i   (in_valid),
        .data_vs1_i   (vs1),
        .data_vs2_i   (vs2),
        .data_vd_o    (vd),
        .out_valid_o  (out_valid),
        .busy_o       (busy),
        .done_o       (done),
        .vxsat_o      (vxsat)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic bus64_t next_bits(input int n);
        bus64_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input bus64_t got, input bus64_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch %s: got 0x%016h expected 0x%016h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_with_error("out_valid_o pulsed while no destination word was due");
            end else begin
                check_word("data_vd_o", vd, exp_q.pop_front());
                check_flag("done_o", done, exp_q.size() == 0);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_error("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic load_random_words(input int n);
        for (int k = 0; k < n; k++) begin
            vs2_q.push_back(next_bits(64));
            vs1_q.push_back(next_bits(64));
        end
    endtask

    // one operation over the words in vs1_q and vs2_q
    task automatic run_op(input instr_type_t it, input sew_t s, input vxrm_t rm, input logic gaps);
        int          n;
        int          gap;
        logic [31:0] half;
        logic [31:0] lo;
        logic        lane_sat;
        logic        sat_exp;
        n       = vs2_q.size();
        sat_exp = 1'b0;
        lo      = '0;
        for (int k = 0; k < n; k++) begin
            half    = ref_narrow_word(it, s, rm, vs1_q[k], vs2_q[k], lane_sat);
            sat_exp = sat_exp | lane_sat;
            if (k % 2 == 1) begin
                exp_q.push_back(ref_pack(lo, half, 1'b1));
            end else if (k == n - 1) begin
                exp_q.push_back(ref_pack(half, 32'h0, 1'b0));
            end else begin
                lo = half;
            end
        end
        @(negedge clk);
        start      = 1'b1;
        instr_type = it;
        sew        = s;
        vxrm       = rm;
        n_words    = CNT_W'(n);
        @(negedge clk);
        start = 1'b0;
        check_flag("busy_o", busy, 1'b1);  // high from the cycle after start
        for (int k = 0; k < n; k++) begin
            gap = gaps ? int'(next_bits(2)) : 0;
            repeat (gap) @(negedge clk);
            in_valid = 1'b1;
            vs1      = vs1_q[k];
            vs2      = vs2_q[k];
            @(negedge clk);
            in_valid = 1'b0;
        end
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        check_flag("out_valid_o", out_valid, 1'b1);
        @(negedge clk);
        check_flag("busy_o", busy, 1'b0);
        check_flag("vxsat_o", vxsat, sat_exp);  // held after done
        vs1_q.delete();
        vs2_q.delete();
        if (exp_q.size() != 0) begin
            stop_with_error("operation ended with destination words still missing");
        end
    endtask

    task automatic test_reset_idle();
        check_flag("busy_o", busy, 1'b0);
        check_flag("out_valid_o", out_valid, 1'b0);
        check_flag("done_o", done, 1'b0);
        check_flag("vxsat_o", vxsat, 1'b0);
        for (int k = 0; k < 4; k++) begin
            in_valid = 1'b1;
            vs1      = next_bits(64);
            vs2      = next_bits(64);
            @(negedge clk);
        end
        in_valid = 1'b0;
        repeat (2) @(negedge clk);
        check_flag("busy_o", busy, 1'b0);
    endtask

    task automatic test_rounding();
        for (int m = 0; m < 4; m++) begin
            vs2_q.push_back(64'hffd8_0029_0038_0028);  // ties of both parities
            vs1_q.push_back(64'h0000_0000_0404_0404);
            vs2_q.push_back(64'h0017_ffe9_0030_0006);
            vs1_q.push_back(64'h0000_0000_0103_0402);
            run_op(VNCLIP, SEW_8, vxrm_t'(m), 1'b0);
            check_flag("vxsat_o", vxsat, 1'b0);
        end
    endtask

    task automatic test_saturation();
        sew_t s;
        for (int j = 0; j < 6; j++) begin
            s = (j / 2 == 0) ? SEW_8 : (j / 2 == 1) ? SEW_16 : SEW_32;
            vs2_q.push_back(64'h7fff_8000_7fff_8000);  // out of range at every width
            vs1_q.push_back(64'h0);
            run_op((j % 2 == 0) ? VNCLIP : VNCLIPU, s, RNU_V, 1'b0);
            check_flag("vxsat_o", vxsat, 1'b1);
        end
        vs2_q.push_back(64'h0000_1234_0000_0042);
        vs1_q.push_back(64'h0);
        run_op(VNCLIPU, SEW_16, RNU_V, 1'b0);
        check_flag("vxsat_o", vxsat, 1'b0);
    endtask

    // even count gives full words, odd count ends in a zero padded half
    task automatic test_packing();
        load_random_words(6);
        run_op(VNCLIPU, SEW_32, RNE_V, 1'b0);
        load_random_words(5);
        run_op(VNCLIP, SEW_16, ROD_V, 1'b0);
    endtask

    task automatic test_random_stream();
        int          left;
        int          n;
        instr_type_t it;
        sew_t        s;
        logic [1:0]  sel;
        left = 40;
        while (left > 0) begin
            n = 1 + int'(next_bits(3));
            if (n > left) begin
                n = left;
            end
            it  = (next_bits(1) != 0) ? VNCLIPU : VNCLIP;
            sel = 2'(next_bits(2));
            s   = (sel == 2'd0) ? SEW_8 : (sel == 2'd1) ? SEW_16 : SEW_32;
            load_random_words(n);
            run_op(it, s, vxrm_t'(next_bits(2)), 1'b1);
            left = left - n;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        instr_type = VNCLIP;
        sew        = SEW_8;
        vxrm       = RNU_V;
        n_words    = '0;
        in_valid   = 1'b0;
        vs1        = '0;
        vs2        = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_reset_idle();
        test_rounding();
        test_saturation();
        test_packing();
        test_random_stream();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: vnclip_unit.f
+incdir+tb
design/drac_pkg.sv
design/riscv_pkg.sv
design/beat_counter.sv
design/narrow_packer.sv
design/vnclip.sv
design/vnclip_ctrl.sv
design/vnclip_unit.sv
tb/vnclip_unit_sva.sv
tb/vnclip_unit_tb.sv

// File: Makefile
# Verilator build and run of the vnclip unit testbench

SIM = obj_dir/Vvnclip_unit_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module vnclip_unit_tb -f vnclip_unit.f

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "simulation gave no result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
